// File: src/bd_out_config.svh
`ifndef BD_OUT_CONFIG_SVH
`define BD_OUT_CONFIG_SVH

// raw word width as it leaves the chip funnel
`define BD_RAW_W 40
// widest decoded leaf payload (leaf 0)
`define BD_PAYLOAD_W 38

// host link beat fields
`define PC_DATA_W 24
`define PC_CODE_W 8

// entries per queue
`define FIFO_DEPTH 4

// 13 funnel leaves plus the invalid code
`define N_LEAF 14

// config register map
`define CFG_ADDR_W 2
`define CFG_ADDR_MASK 0
`define CFG_ADDR_DROPS 1

`endif

// File: src/bd_out_pkg.sv
package bd_out_pkg;

  `include "bd_out_config.svh"

  // leaf numbering follows the funnel tree, invalid sits past the last leaf
  typedef enum logic [3:0] {
    LEAF_0, LEAF_1, LEAF_2, LEAF_3, LEAF_4, LEAF_5, LEAF_6,
    LEAF_7, LEAF_8, LEAF_9, LEAF_10, LEAF_11, LEAF_12, LEAF_INVALID
  } leaf_code_t;

  typedef struct packed {
    logic [`BD_RAW_W-1:0] word;
  } raw_bd_word_t;

  typedef struct packed {
    leaf_code_t                leaf_code;
    logic [`BD_PAYLOAD_W-1:0] payload;
  } decoded_bd_word_t;

  typedef struct packed {
    logic [`PC_CODE_W-1:0] code;
    logic [`PC_DATA_W-1:0] payload;
  } serialized_pc_word_t;

  // prefixes are right aligned, compared against the top bits of the raw word
  // the set is prefix free, 111111 is left unused and decodes as invalid
  localparam logic [7:0] leaf_prefix [0:`N_LEAF-1] = '{
    8'b00, 8'b1010, 8'b1011, 8'b1100, 8'b1101, 8'b11100, 8'b0110,
    8'b0111, 8'b11101, 8'b11110, 8'b111110, 8'b100, 8'b010, 8'b0
  };

  localparam int leaf_prefix_len [0:`N_LEAF-1] = '{
    2, 4, 4, 4, 4, 5, 4, 4, 5, 5, 6, 3, 3, 0
  };

  // payload bits after the prefix; invalid carries the low 38 raw bits
  localparam int leaf_width [0:`N_LEAF-1] = '{
    38, 24, 20, 19, 16, 11, 29, 29, 22, 24, 12, 28, 32, 38
  };

endpackage

// File: src/leaf_route_regs.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module leaf_route_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfg_we,
  input  logic [`CFG_ADDR_W-1:0] cfg_addr,
  input  logic [15:0]            cfg_wdata,
  output logic [15:0]            cfg_rdata,
  output logic [`N_LEAF-1:0]     drop_mask,
  input  logic                   drop_pulse
);

  logic [15:0] drop_count;
  logic        count_clear;

  // any write to the counter address zeroes it, data ignored
  assign count_clear = cfg_we && (cfg_addr == `CFG_ADDR_W'(`CFG_ADDR_DROPS));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      drop_mask <= '0;
    end else if (cfg_we && (cfg_addr == `CFG_ADDR_W'(`CFG_ADDR_MASK))) begin
      drop_mask <= cfg_wdata[`N_LEAF-1:0];
    end
  end

  // saturating, a clear wins over a drop in the same cycle
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      drop_count <= '0;
    end else if (count_clear) begin
      drop_count <= '0;
    end else if (drop_pulse && (drop_count != 16'hffff)) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  // read mux, unmapped addresses read as zero
  always_comb begin
    cfg_rdata = '0;
    if (cfg_addr == `CFG_ADDR_W'(`CFG_ADDR_MASK))
      cfg_rdata = 16'(drop_mask);
    else if (cfg_addr == `CFG_ADDR_W'(`CFG_ADDR_DROPS))
      cfg_rdata = drop_count;
  end

  a_count_no_wrap: assert property (@(posedge clk) disable iff (reset)
    (drop_count == 16'hffff) && !count_clear |=> (drop_count == 16'hffff));

endmodule

// File: src/funnel_decoder.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module funnel_decoder import bd_out_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  raw_bd_word_t         raw_in,
  input  logic                 raw_v,
  output logic                 raw_a,
  input  logic [`N_LEAF-1:0]   drop_mask,
  output logic                 drop_pulse,
  output decoded_bd_word_t     dec_out,
  output logic                 dec_v,
  input  logic                 dec_a
);

  localparam int RAW_W = `BD_RAW_W;

  leaf_code_t                dec_leaf;
  logic [RAW_W-1:0]          field;
  logic [`BD_PAYLOAD_W-1:0]  dec_payload;
  logic                      accept;
  logic                      dropped;

  // prefix match against the table, at most one leaf can hit
  always_comb begin
    dec_leaf = LEAF_INVALID;
    field = raw_in.word;
    for (int i = 0; i < `N_LEAF - 1; i++) begin
      if ((raw_in.word >> (RAW_W - leaf_prefix_len[i])) == RAW_W'(leaf_prefix[i])) begin
        dec_leaf = leaf_code_t'(i);
        // drop the tail below the field, then mask off the prefix above it
        field = (raw_in.word >> (RAW_W - leaf_prefix_len[i] - leaf_width[i]))
                & ((RAW_W'(1) << leaf_width[i]) - RAW_W'(1));
      end
    end
    // invalid keeps the raw low bits untouched
    dec_payload = field[`BD_PAYLOAD_W-1:0];
  end

  // output register free now or freed this cycle
  assign raw_a      = !dec_v || dec_a;
  assign accept     = raw_v && raw_a;
  assign dropped    = drop_mask[dec_leaf];
  assign drop_pulse = accept && dropped;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      dec_v <= 1'b0;
    end else if (accept && !dropped) begin
      dec_v <= 1'b1;
    end else if (dec_a) begin
      dec_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !dropped) begin
      dec_out.leaf_code <= dec_leaf;
      dec_out.payload   <= dec_payload;
    end
  end

  // word under back-pressure must not change before the sink takes it
  a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
    dec_v && !dec_a |=> dec_v && $stable(dec_out));

endmodule

// File: src/word_fifo.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module word_fifo #(
  parameter type item_t = logic
) (
  input  logic  clk,
  input  logic  reset,
  input  item_t in_data,
  input  logic  in_v,
  output logic  in_a,
  output item_t out_data,
  output logic  out_v,
  input  logic  out_a
);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_a  = (count != CNT_W'(DEPTH));
  assign out_v = (count != '0);
  // show-ahead, head entry always on the output
  assign out_data = mem[rd_ptr];

  assign push = in_v && in_a;
  assign pop  = out_v && out_a;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // pointers wrap explicitly so any depth works
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      if (push && !pop)
        count <= count + CNT_W'(1);
      else if (pop && !push)
        count <= count - CNT_W'(1);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));
  // an empty queue has its pointers together
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

// File: src/leaf_serializer.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module leaf_serializer import bd_out_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  decoded_bd_word_t    dec_in,
  input  logic                dec_v,
  output logic                dec_a,
  output serialized_pc_word_t ser_out,
  output logic                ser_v,
  input  logic                ser_a
);

  // low beat first, high beat only for leaves wider than one host payload
  typedef enum logic {
    SEND_LOW,
    SEND_HIGH
  } ser_state_t;

  ser_state_t state;
  logic       wide;
  logic       beat_done;

  // second beat derived from the width table
  assign wide      = (leaf_width[dec_in.leaf_code] > `PC_DATA_W);
  assign beat_done = dec_v && ser_a;

  // beat follows the queue head directly
  assign ser_v = dec_v;

  always_comb begin
    ser_out.code = `PC_CODE_W'(dec_in.leaf_code);
    if (state == SEND_LOW)
      ser_out.payload = dec_in.payload[`PC_DATA_W-1:0];
    else
      ser_out.payload = `PC_DATA_W'(dec_in.payload[`BD_PAYLOAD_W-1:`PC_DATA_W]);
  end

  // input word released only with its last beat
  assign dec_a = ser_a && ((state == SEND_HIGH) || !wide);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= SEND_LOW;
    end else if (beat_done) begin
      if ((state == SEND_LOW) && wide)
        state <= SEND_HIGH;
      else
        state <= SEND_LOW;
    end
  end

  // high beat only ever sent for a wide word still held at the input
  a_high_only_wide: assert property (@(posedge clk) disable iff (reset)
    (state == SEND_HIGH) |-> dec_v && wide);

endmodule

// File: src/bd_out_top.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module bd_out_top import bd_out_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  raw_bd_word_t           raw_in,
  input  logic                   raw_v,
  output logic                   raw_a,
  output serialized_pc_word_t    pc_out,
  output logic                   pc_v,
  input  logic                   pc_a,
  input  logic                   cfg_we,
  input  logic [`CFG_ADDR_W-1:0] cfg_addr,
  input  logic [15:0]            cfg_wdata,
  output logic [15:0]            cfg_rdata
);

  logic [`N_LEAF-1:0]  drop_mask;
  logic                drop_pulse;
  // decoder to first queue
  decoded_bd_word_t    dec_word;
  logic                dec_v;
  logic                dec_a;
  // first queue to serializer
  decoded_bd_word_t    ser_in;
  logic                ser_in_v;
  logic                ser_in_a;
  // serializer to host queue
  serialized_pc_word_t beat;
  logic                beat_v;
  logic                beat_a;

  leaf_route_regs i_regs (.clk, .reset, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
                          .drop_mask, .drop_pulse);

  funnel_decoder i_dec (.clk, .reset, .raw_in, .raw_v, .raw_a, .drop_mask, .drop_pulse,
                        .dec_out(dec_word), .dec_v, .dec_a);

  word_fifo #(.item_t(decoded_bd_word_t)) i_dec_q (
    .clk, .reset, .in_data(dec_word), .in_v(dec_v), .in_a(dec_a),
    .out_data(ser_in), .out_v(ser_in_v), .out_a(ser_in_a));

  leaf_serializer i_ser (.clk, .reset, .dec_in(ser_in), .dec_v(ser_in_v), .dec_a(ser_in_a),
                         .ser_out(beat), .ser_v(beat_v), .ser_a(beat_a));

  word_fifo #(.item_t(serialized_pc_word_t)) i_pc_q (
    .clk, .reset, .in_data(beat), .in_v(beat_v), .in_a(beat_a),
    .out_data(pc_out), .out_v(pc_v), .out_a(pc_a));

endmodule

// File: tests/tb_bd_out.sv
`timescale 1ns/1ps
`include "bd_out_config.svh"

module tb_bd_out import bd_out_pkg::*;;

  localparam int WAIT_LIMIT = 400;
  localparam int EXP_DEPTH  = 1024;
  localparam logic [`CFG_ADDR_W-1:0] ADDR_MASK  = `CFG_ADDR_W'(`CFG_ADDR_MASK);
  localparam logic [`CFG_ADDR_W-1:0] ADDR_DROPS = `CFG_ADDR_W'(`CFG_ADDR_DROPS);

  logic                   clk;
  logic                   reset;
  raw_bd_word_t           raw_in;
  logic                   raw_v;
  logic                   raw_a;
  serialized_pc_word_t    pc_out;
  logic                   pc_v;
  logic                   pc_a;
  logic                   cfg_we;
  logic [`CFG_ADDR_W-1:0] cfg_addr;
  logic [15:0]            cfg_wdata;
  logic [15:0]            cfg_rdata;

  // expected beats, written by the stimulus and consumed on each pc handshake
  serialized_pc_word_t exp_mem [EXP_DEPTH];
  int                  exp_wr = 0;
  int                  exp_rd = 0;
  serialized_pc_word_t exp_head;
  logic                exp_pending;
  logic [7:0]          exp_code;
  logic [23:0]         exp_data;
  logic [7:0]          pc_code;
  logic [23:0]         pc_data;

  int                 value_errors = 0;
  int                 other_errors = 0;
  int                 timeout_errors = 0;
  int                 dropped_words = 0;
  bit                 aborted = 1'b0;
  bit                 stall_mode = 1'b0;
  logic [`N_LEAF-1:0] mask_copy = '0;

  bd_out_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // host side ready, random back-pressure only in stall mode
  initial begin
    pc_a = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      pc_a = stall_mode ? ($urandom_range(0, 2) == 0) : 1'b1;
    end
  end

  assign exp_head    = exp_mem[exp_rd];
  assign exp_pending = (exp_rd != exp_wr);
  assign exp_code    = exp_head.code;
  assign exp_data    = exp_head.payload;
  assign pc_code     = pc_out.code;
  assign pc_data     = pc_out.payload;

  always @(posedge clk) begin
    if (!reset && pc_v && pc_a && exp_pending)
      exp_rd <= exp_rd + 1;
  end

  a_beat_expected: assert property (@(posedge clk) disable iff (reset)
    pc_v && pc_a |-> exp_pending)
    else begin
      other_errors++;
      $display("pc beat accepted while no beat was expected");
    end

  a_beat_code: assert property (@(posedge clk) disable iff (reset)
    pc_v && pc_a && exp_pending |-> pc_code == exp_code)
    else begin
      value_errors++;
      $display("ERR pc_out.code exp %h got %h", $sampled(exp_code), $sampled(pc_code));
    end

  a_beat_payload: assert property (@(posedge clk) disable iff (reset)
    pc_v && pc_a && exp_pending |-> pc_data == exp_data)
    else begin
      value_errors++;
      $display("ERR pc_out.payload exp %h got %h", $sampled(exp_data), $sampled(pc_data));
    end

  // nothing leaves and raw input stays open while in reset
  a_reset_idle: assert property (@(posedge clk) reset |-> !pc_v && raw_a)
    else begin
      other_errors++;
      $display("pc_v high or raw_a low while reset is held");
    end

  task automatic report_timeout(input string what);
    timeout_errors++;
    aborted = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  // one beat for narrow leaves, low part then high part for wide ones
  task automatic push_expected(input int leaf, input logic [37:0] payload);
    exp_mem[exp_wr] = '{code: 8'(leaf), payload: payload[23:0]};
    exp_wr++;
    if (leaf_width[leaf] > `PC_DATA_W) begin
      exp_mem[exp_wr] = '{code: 8'(leaf), payload: 24'(payload[37:24])};
      exp_wr++;
    end
  endtask

  task automatic write_reg(input logic [`CFG_ADDR_W-1:0] addr, input logic [15:0] data);
    if (aborted) return;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    if (addr == ADDR_MASK)
      mask_copy = data[`N_LEAF-1:0];
  endtask

  // read data is combinational, sampled mid cycle
  task automatic check_reg(input logic [`CFG_ADDR_W-1:0] addr, input logic [15:0] expected);
    if (aborted) return;
    cfg_addr = addr;
    @(negedge clk);
    assert (cfg_rdata == expected) else begin
      value_errors++;
      $display("ERR cfg_rdata addr %h exp %h got %h", addr, expected, cfg_rdata);
    end
    @(posedge clk);
    #1;
  endtask

  // holds raw_v until a cycle with raw_a high has passed an edge
  task automatic send_raw(input logic [39:0] word);
    bit ok;
    int n;
    if (aborted) return;
    ok = 1'b0;
    raw_in.word = word;
    raw_v = 1'b1;
    for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
      @(negedge clk);
      ok = raw_a;
      @(posedge clk);
      #1;
    end
    raw_v = 1'b0;
    if (!ok)
      report_timeout("raw_a");
  endtask

  // raw word = prefix, payload field, random tail below the field
  task automatic send_leaf(input int leaf);
    logic [63:0] rnd;
    logic [63:0] tail;
    logic [63:0] pay;
    logic [63:0] w;
    int          plen;
    int          pw;
    int          low;
    if (aborted) return;
    rnd  = {$urandom, $urandom};
    tail = {$urandom, $urandom};
    if (leaf == int'(LEAF_INVALID)) begin
      // 111111 matches no prefix, the low 38 bits travel as payload
      w   = {24'h0, 6'h3f, rnd[33:0]};
      pay = {26'h0, w[37:0]};
    end else begin
      plen = leaf_prefix_len[leaf];
      pw   = leaf_width[leaf];
      low  = 40 - plen - pw;
      pay  = rnd & ((64'd1 << pw) - 64'd1);
      tail = tail & ((64'd1 << low) - 64'd1);
      w    = (64'(leaf_prefix[leaf]) << (40 - plen)) | (pay << low) | tail;
    end
    if (mask_copy[leaf])
      dropped_words++;
    else
      push_expected(leaf, pay[37:0]);
    send_raw(w[39:0]);
  endtask

  task automatic wait_drained();
    int n;
    if (aborted) return;
    for (n = 0; n < WAIT_LIMIT && exp_rd != exp_wr; n++) begin
      @(posedge clk);
      #1;
    end
    if (exp_rd != exp_wr)
      report_timeout("expected pc beats to drain");
  endtask

  task automatic finish_run();
    $display("errors: value %0d, other %0d, timeout %0d",
             value_errors, other_errors, timeout_errors);
    if (value_errors + other_errors + timeout_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  initial begin : main_seq
    int leaf;
    void'($urandom(60708));
    reset     = 1'b1;
    raw_in    = '0;
    raw_v     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle state right after reset
    @(negedge clk);
    assert (!pc_v && raw_a) else begin
      other_errors++;
      $display("pc_v high or raw_a low right after reset");
    end
    @(posedge clk);
    #1;
    check_reg(ADDR_MASK, 16'h0000);
    check_reg(ADDR_DROPS, 16'h0000);

    // every leaf and the invalid code, twice each
    for (int pass = 0; pass < 2; pass++) begin
      for (leaf = 0; leaf < `N_LEAF; leaf++)
        send_leaf(leaf);
    end
    wait_drained();

    // drop leaf 2 (narrow) and leaf 11 (wide)
    write_reg(ADDR_MASK, 16'h0804);
    check_reg(ADDR_MASK, 16'h0804);
    send_leaf(2);
    send_leaf(11);
    for (int i = 0; i < 22; i++)
      send_leaf(int'($urandom_range(0, `N_LEAF - 1)));
    wait_drained();
    check_reg(ADDR_DROPS, 16'(dropped_words));
    write_reg(ADDR_DROPS, 16'h0000);
    check_reg(ADDR_DROPS, 16'h0000);
    write_reg(ADDR_MASK, 16'h0000);

    // random stream under random host back-pressure
    stall_mode = 1'b1;
    for (int i = 0; i < 80; i++)
      send_leaf(int'($urandom_range(0, `N_LEAF - 1)));
    stall_mode = 1'b0;
    wait_drained();
    if (!aborted) begin
      // quiet window, a stray beat would still be on its way out here
      repeat (2 * `FIFO_DEPTH + 4) @(posedge clk);
      @(negedge clk);
      assert (!pc_v && (exp_rd == exp_wr)) else begin
        other_errors++;
        $display("pc output still busy after the expected beats drained");
      end
      @(posedge clk);
      #1;
    end

    finish_run();
  end

endmodule

// File: project.f
+incdir+src
src/bd_out_pkg.sv
src/leaf_route_regs.sv
src/funnel_decoder.sv
src/word_fifo.sv
src/leaf_serializer.sv
src/bd_out_top.sv
tests/tb_bd_out.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f project.f --top-module tb_bd_out -o sim_bd_out
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_bd_out 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the verdict is the pass line in the simulation output
if printf '%s\n' "$sim_out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
